/* build.f */
reflet_isa_pkg.sv
reflet_mem_pkg.sv
reflet_addr.sv
reflet_alignement_fixer.sv
reflet_mem_unit.sv
reflet_mem_unit_tb.sv

/* reflet_mem_unit_tb.sv */
// testbench with clock, reset, word ram model, reference function, compare tasks and report
`timescale 1ns/1ns

module reflet_mem_unit_tb;
    import reflet_isa_pkg::*;
    import reflet_mem_pkg::*;

    logic        clk;
    logic        reset;
    logic        enable;
    cpu_regs_t   regs;
    logic [1:0]  reduced_behaviour_bits;
    word_t       data_in;
    ram_req_t    ram_req;
    cpu_result_t result;
    logic [7:0]  instruction;
    logic        ram_not_ready;
    logic        byte_mode;
    logic        alignement_error;

    // ram words indexed by byte address bits 8 to 1
    word_t       mem [0:255];
    cpu_result_t exp_result;
    string       op_name;
    int          pulses;
    logic        bm;

    reflet_mem_unit i_reflet_mem_unit (
        .clk                    (clk),
        .reset                  (reset),
        .enable                 (enable),
        .regs                   (regs),
        .reduced_behaviour_bits (reduced_behaviour_bits),
        .data_in                (data_in),
        .ram_req                (ram_req),
        .result                 (result),
        .instruction            (instruction),
        .ram_not_ready          (ram_not_ready),
        .byte_mode              (byte_mode),
        .alignement_error       (alignement_error)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = !clk;
    end

    // word ram with one cycle read latency and whole word writes
    always @(posedge clk) begin
        data_in <= #1 mem[ram_req.addr[8:1]];
        if (ram_req.write_en) begin
            mem[ram_req.addr[8:1]] <= ram_req.data;
        end
    end

    // result seen by the cpu on every update_pc cycle
    always @(posedge clk) begin
        if (reset && result.update_pc) begin
            pulses = pulses + 1;
            check_result(op_name, exp_result, result);
        end
    end

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_result(input string name, input cpu_result_t exp, input cpu_result_t act);
        if (act !== exp) begin
            stop_run($sformatf("FAIL %s result expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            stop_run($sformatf("FAIL %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            stop_run($sformatf("FAIL %s expected %b actual %b", name, exp, act));
        end
    endtask

    // expected outcome of one instruction, worked out from the access rules
    function automatic cpu_result_t expect_op(
        input  logic [7:0] inst,
        input  cpu_regs_t  r,
        input  logic [1:0] width_bits,
        input  logic       byte_on,
        output logic [7:0] widx,
        output word_t      new_word,
        output logic       err,
        output int         cycles
    );
        cpu_result_t res;
        word_t       addr;
        word_t       old_word;
        word_t       rval;
        word_t       wdata;
        logic        stack;
        logic        rd;
        logic        wr;
        logic        one_byte;
        stack = (inst == inst_push) || (inst == inst_pop) || (inst == inst_call) ||
                (inst == inst_ret);
        rd = (inst == inst_pop) || (inst == inst_ret) || (inst[7:4] == opp_load);
        wr = (inst == inst_push) || (inst == inst_call) || (inst[7:4] == opp_str);
        if (inst == inst_pop || inst == inst_ret) begin
            addr = r.sp - 16'd2;
        end else begin
            addr = stack ? r.sp : r.other;
        end
        widx = addr[8:1];
        old_word = mem[widx];
        one_byte = !stack && (byte_on || width_bits >= 2'b10);
        err = (rd || wr) && !one_byte && addr[0];
        wdata = (inst == inst_call) ? r.pc : r.working;
        new_word = old_word;
        if (wr && !err && !one_byte) begin
            new_word = wdata;
        end else if (wr && !err) begin
            new_word[{addr[0], 3'b000} +: 8] = wdata[7:0];
        end
        rval = one_byte ? word_t'(old_word[{addr[0], 3'b000} +: 8]) : old_word;
        if (err) begin
            rval = '0;
        end
        res.update_pc = 1'b1;
        res.reg_id = (inst == inst_call || inst == inst_ret) ? pc_id : 4'd0;
        if (rd) begin
            res.value = (inst == inst_ret) ? rval + 16'd1 : rval;
        end else begin
            res.value = (wr || inst == inst_tbm) ? r.working : '0;
        end
        cycles = 5 + (rd ? 1 : 0) + ((wr && one_byte) ? 1 : 0);
        return res;
    endfunction

    // pc kept in the upper half of the ram and data in the lower half
    task automatic load_regs(input word_t data_addr, input word_t stack_ptr);
        regs.working = word_t'($urandom);
        regs.pc = 16'h0100 | word_t'($urandom % 256);
        regs.sp = stack_ptr;
        regs.other = data_addr;
    endtask

    // one instruction from fetch to register update
    task automatic run_op(input string name, input logic [7:0] inst, input int stall);
        logic [7:0] widx;
        word_t      new_word;
        logic       exp_err;
        logic       err_seen;
        logic       done;
        int         exp_cycles;
        int         cycles;
        int         pulses_start;
        mem[regs.pc[8:1]][{regs.pc[0], 3'b000} +: 8] = inst;
        exp_result = expect_op(inst, regs, reduced_behaviour_bits, bm, widx, new_word,
                               exp_err, exp_cycles);
        op_name = name;
        pulses_start = pulses;
        err_seen = 1'b0;
        done = 1'b0;
        cycles = 0;
        while (!done) begin
            @(posedge clk);
            cycles = cycles + 1;
            err_seen = err_seen | alignement_error;
            done = !ram_not_ready;
            if (cycles > 40) begin
                stop_run($sformatf("%s did not reach update_regs within 40 cycles", name));
            end
            // stall while in save_instruction
            #1 enable = (cycles >= stall + 1);
        end
        if (inst == inst_tbm) begin
            bm = !bm;
        end
        check_word({name, " instruction"}, word_t'(inst), word_t'(instruction));
        check_word({name, " cycles"}, word_t'(exp_cycles + stall), word_t'(cycles));
        check_word({name, " memory"}, new_word, mem[widx]);
        check_word({name, " update_pc count"}, 16'd1, word_t'(pulses - pulses_start));
        check_flag({name, " alignment error"}, exp_err, err_seen);
        check_flag({name, " byte mode"}, bm, byte_mode);
    endtask

    initial begin
        void'($urandom(71));
        reset = 1'b0;
        enable = 1'b1;
        regs = '0;
        reduced_behaviour_bits = 2'b00;
        data_in = '0;
        pulses = 0;
        bm = 1'b0;
        op_name = "reset";
        exp_result = '0;
        for (int i = 0; i < 256; i++) begin
            mem[i] = word_t'(i * 16'h0101) ^ 16'h3c5a;
        end
        repeat (4) @(posedge clk);
        check_flag("reset update_pc", 1'b0, result.update_pc);
        check_flag("reset write_en", 1'b0, ram_req.write_en);
        check_flag("reset alignment error", 1'b0, alignement_error);
        check_flag("reset byte mode", 1'b0, byte_mode);
        check_flag("reset ram_not_ready", 1'b1, ram_not_ready);
        #1 reset = 1'b1;
        load_regs(16'h0020, 16'h0010);
        run_op("compute", 8'h01, 0);
        for (int i = 0; i < 2; i++) begin
            run_op("tbm", inst_tbm, i);
        end
        // loads and stores over every width setting with byte mode flipped now and then
        for (int i = 0; i < 40; i++) begin
            if ($urandom % 4 == 0) begin
                run_op("tbm", inst_tbm, 0);
            end
            load_regs(word_t'($urandom % 256), 16'h0010);
            reduced_behaviour_bits = 2'($urandom);
            if (i % 2 == 0) begin
                run_op("load", {opp_load, 4'($urandom)}, $urandom % 4);
            end else begin
                run_op("store", {opp_str, 4'($urandom)}, $urandom % 4);
            end
        end
        // stack pointer always even here
        for (int i = 0; i < 8; i++) begin
            load_regs(16'h0040, word_t'(($urandom % 127 + 1) * 2));
            case (i % 4)
                0: run_op("push", inst_push, $urandom % 4);
                1: run_op("call", inst_call, $urandom % 4);
                2: run_op("pop", inst_pop, $urandom % 4);
                default: run_op("ret", inst_ret, $urandom % 4);
            endcase
        end
        if (bm) begin
            run_op("tbm", inst_tbm, 0);
        end
        reduced_behaviour_bits = 2'b01;
        load_regs(16'h0033, 16'h0010);
        run_op("odd load", {opp_load, 4'h1}, 0);
        load_regs(16'h0051, 16'h0010);
        run_op("odd store", {opp_str, 4'h2}, 2);
        $display("*** PASSED ***");
        $finish;
    end

endmodule

/* reflet_mem_unit.sv */
// memory access unit top joining the sequencer and the alignment fixer
`timescale 1ns/1ns

module reflet_mem_unit (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        enable,
    input  reflet_mem_pkg::cpu_regs_t   regs,
    input  logic [1:0]                  reduced_behaviour_bits,
    input  reflet_mem_pkg::word_t       data_in,
    output reflet_mem_pkg::ram_req_t    ram_req,
    output reflet_mem_pkg::cpu_result_t result,
    output logic [7:0]                  instruction,
    output logic                        ram_not_ready,
    output logic                        byte_mode,
    output logic                        alignement_error
);
    import reflet_mem_pkg::*;

    ram_req_t     cpu_req;
    access_size_t size;
    logic         cpu_active;
    word_t        fix_data;
    logic         fix_ready;

    reflet_addr i_reflet_addr (
        .clk                    (clk),
        .reset                  (reset),
        .enable                 (enable),
        .regs                   (regs),
        .reduced_behaviour_bits (reduced_behaviour_bits),
        .fix_ready              (fix_ready),
        .fix_data               (fix_data),
        .instruction            (instruction),
        .cpu_req                (cpu_req),
        .size                   (size),
        .cpu_active             (cpu_active),
        .result                 (result),
        .ram_not_ready          (ram_not_ready),
        .byte_mode              (byte_mode)
    );

    reflet_alignement_fixer i_reflet_alignement_fixer (
        .clk              (clk),
        .reset            (reset),
        .cpu_req          (cpu_req),
        .size             (size),
        .cpu_active       (cpu_active),
        .cpu_data         (fix_data),
        .ready            (fix_ready),
        .alignement_error (alignement_error),
        .ram_req          (ram_req),
        .data_in          (data_in)
    );

endmodule

/* reflet_alignement_fixer.sv */
// byte lane selection, byte read-modify-write and misalignment check
`timescale 1ns/1ns

module reflet_alignement_fixer (
    input  logic                         clk,
    input  logic                         reset,
    input  reflet_mem_pkg::ram_req_t     cpu_req,
    input  reflet_mem_pkg::access_size_t size,
    input  logic                         cpu_active,
    output reflet_mem_pkg::word_t        cpu_data,
    output logic                         ready,
    output logic                         alignement_error,
    output reflet_mem_pkg::ram_req_t     ram_req,
    input  reflet_mem_pkg::word_t        data_in
);
    import reflet_mem_pkg::*;

    logic       odd_addr;
    logic       misaligned;
    logic       byte_write;
    logic       insert_read;
    logic       rmw_pending;
    logic       lane_r;
    logic       byte_r;
    logic       error_r;
    logic [7:0] lane_byte;
    word_t      merged_word;

    assign odd_addr = cpu_req.addr[0];

    // word access on an odd byte address
    assign misaligned       = cpu_active && (size == access_word) && odd_addr;
    assign alignement_error = misaligned;

    // no byte mask on the ram, so a byte write reads the word first
    assign byte_write  = cpu_active && cpu_req.write_en && (size == access_byte);
    assign insert_read = byte_write && !rmw_pending;
    assign ready       = !insert_read;

    always_ff @(posedge clk) begin
        if (!reset) begin
            rmw_pending <= 1'b0;
            error_r     <= 1'b0;
        end else begin
            rmw_pending <= insert_read;
            error_r     <= misaligned;
        end
    end

    // lane and width of the word coming back next cycle
    always_ff @(posedge clk) begin
        lane_r <= odd_addr;
        byte_r <= (size == access_byte);
    end

    // read path returns a zero-extended byte from the addressed lane
    assign lane_byte = lane_r ? data_in[word_size-1 -: 8] : data_in[7:0];

    always_comb begin
        if (error_r) begin
            cpu_data = '0;
        end else if (byte_r) begin
            cpu_data = word_t'(lane_byte);
        end else begin
            cpu_data = data_in;
        end
    end

    // new byte into its lane and the other lane from the word just read
    always_comb begin
        if (odd_addr) begin
            merged_word = {cpu_req.data[7:0], data_in[7:0]};
        end else begin
            merged_word = {data_in[word_size-1 -: 8], cpu_req.data[7:0]};
        end
    end

    assign ram_req.addr     = cpu_req.addr;
    assign ram_req.data     = byte_write ? merged_word : cpu_req.data;
    // words write at once and bytes only on the second cycle
    assign ram_req.write_en = cpu_active && cpu_req.write_en && !misaligned &&
                              ((size == access_word) || rmw_pending);

endmodule

/* reflet_addr.sv */
// instruction sequencer with address, write data, width and result selection
`timescale 1ns/1ns

module reflet_addr (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         enable,
    input  reflet_mem_pkg::cpu_regs_t    regs,
    input  logic [1:0]                   reduced_behaviour_bits,
    input  logic                         fix_ready,
    input  reflet_mem_pkg::word_t        fix_data,
    output logic [7:0]                   instruction,
    output reflet_mem_pkg::ram_req_t     cpu_req,
    output reflet_mem_pkg::access_size_t size,
    output logic                         cpu_active,
    output reflet_mem_pkg::cpu_result_t  result,
    output logic                         ram_not_ready,
    output logic                         byte_mode
);
    import reflet_isa_pkg::*;
    import reflet_mem_pkg::*;

    addr_state_t  state;
    word_t        read_data;
    logic         advance;
    logic [3:0]   opperand;
    logic [7:0]   next_instruction;
    logic         data_access;
    word_t        data_addr;
    word_t        write_data;
    access_size_t data_size;

    // only back-pressure in the unit
    assign advance = enable && fix_ready;

    assign opperand         = opperand_of(instruction);
    assign next_instruction = fix_data[7:0];

    // data address held through both read states so a stall keeps data_in valid
    assign data_access = (state == addr_read_prepare) || (state == addr_read) ||
                         (state == addr_write);

    always_comb begin
        if (instruction == inst_pop || instruction == inst_ret) begin
            // stack pointer already moved by the cpu
            data_addr = regs.sp - word_t'(word_size / 8);
        end else if (instruction == inst_push || instruction == inst_call) begin
            data_addr = regs.sp;
        end else if (opperand == opp_str || opperand == opp_load) begin
            data_addr = regs.other;
        end else begin
            data_addr = regs.pc;
        end
    end

    always_comb begin
        if (instruction == inst_call) begin
            write_data = regs.pc;
        end else if (instruction == inst_push || opperand == opp_str) begin
            write_data = regs.working;
        end else begin
            write_data = '0;
        end
    end

    // stack accesses are always full words
    always_comb begin
        if (is_stack_op(instruction)) begin
            data_size = access_word;
        end else if (byte_mode || reduced_behaviour_bits[1]) begin
            data_size = access_byte;
        end else begin
            data_size = access_word;
        end
    end

    // fetch and idle states present pc as a byte
    assign cpu_req.addr     = data_access ? data_addr : regs.pc;
    assign cpu_req.data     = write_data;
    assign cpu_req.write_en = (state == addr_write);
    assign size             = data_access ? data_size : access_byte;
    assign cpu_active       = (state != update_regs);

    always_comb begin
        if (is_mem_read(instruction)) begin
            // ret skips past the call it came from
            result.value = (instruction == inst_ret) ? read_data + 1'b1 : read_data;
        end else if (keeps_working(instruction)) begin
            result.value = regs.working;
        end else begin
            result.value = '0;
        end
    end

    assign result.reg_id    = (instruction == inst_ret || instruction == inst_call) ?
                              pc_id : wr_id;
    assign result.update_pc = (state == update_buff_regs);
    assign ram_not_ready    = (state != update_regs);

    always_ff @(posedge clk) begin
        if (!reset) begin
            state       <= get_instruction;
            instruction <= '0;
            byte_mode   <= 1'b0;
        end else if (advance) begin
            case (state)
                update_regs: begin
                    if (instruction == inst_tbm) begin
                        byte_mode <= !byte_mode;
                    end
                    state <= get_instruction;
                end
                get_instruction: begin
                    state <= save_instruction;
                end
                save_instruction: begin
                    instruction <= next_instruction;
                    if (is_mem_read(next_instruction)) begin
                        state <= addr_read_prepare;
                    end else if (is_mem_write(next_instruction)) begin
                        state <= addr_write;
                    end else begin
                        state <= compute;
                    end
                end
                addr_read_prepare: begin
                    state <= addr_read;
                end
                compute, addr_write, addr_read: begin
                    state <= update_buff_regs;
                end
                default: begin
                    state <= update_regs;
                end
            endcase
        end
    end

    // read word captured as it returns from the fixer
    always_ff @(posedge clk) begin
        if (advance && state == addr_read) begin
            read_data <= fix_data;
        end
    end

endmodule

/* reflet_mem_pkg.sv */
// word size, sequencer states, access width and structs for registers, results and ram bus
package reflet_mem_pkg;

    localparam int word_size = 16;

    typedef logic [word_size-1:0] word_t;

    // sequencer states, one instruction in flight
    typedef enum logic [2:0] {
        update_regs       = 3'd0,
        get_instruction   = 3'd1,
        save_instruction  = 3'd2,
        compute           = 3'd3,
        addr_read_prepare = 3'd4,
        addr_write        = 3'd5,
        addr_read         = 3'd6,
        update_buff_regs  = 3'd7
    } addr_state_t;

    typedef enum logic {
        access_byte = 1'b0,
        access_word = 1'b1
    } access_size_t;

    // registers supplied by the cpu core
    typedef struct packed {
        word_t working;
        word_t pc;
        word_t sp;
        word_t other;
    } cpu_regs_t;

    // value and target register handed back to the cpu
    typedef struct packed {
        word_t      value;
        logic [3:0] reg_id;
        logic       update_pc;
    } cpu_result_t;

    // byte address, bit 0 ignored by the ram
    typedef struct packed {
        word_t addr;
        word_t data;
        logic  write_en;
    } ram_req_t;

endpackage

/* reflet_isa_pkg.sv */
// instruction codes, operand codes, register ids and decode functions
package reflet_isa_pkg;

    // complete one-byte instructions
    localparam logic [7:0] inst_tbm  = 8'h07;
    localparam logic [7:0] inst_push = 8'h09;
    localparam logic [7:0] inst_pop  = 8'h0A;
    localparam logic [7:0] inst_ret  = 8'h0B;
    localparam logic [7:0] inst_call = 8'h0C;

    // operand in the upper nibble
    // the lower nibble names the register
    localparam logic [3:0] opp_str  = 4'hD;
    localparam logic [3:0] opp_load = 4'hE;

    // register ids reported back to the cpu
    localparam logic [3:0] wr_id = 4'd0;
    localparam logic [3:0] pc_id = 4'd3;

    // upper nibble of an instruction
    function automatic logic [3:0] opperand_of(input logic [7:0] inst);
        return inst[7:4];
    endfunction

    // accesses relative to the stack pointer
    function automatic logic is_stack_op(input logic [7:0] inst);
        logic hit;
        hit = (inst == inst_push) || (inst == inst_pop) ||
              (inst == inst_call) || (inst == inst_ret);
        return hit;
    endfunction

    // instructions that fetch a data word from ram
    function automatic logic is_mem_read(input logic [7:0] inst);
        logic hit;
        hit = (inst == inst_pop) || (inst == inst_ret) ||
              (opperand_of(inst) == opp_load);
        return hit;
    endfunction

    // instructions that store into ram
    function automatic logic is_mem_write(input logic [7:0] inst);
        logic hit;
        hit = (inst == inst_push) || (inst == inst_call) ||
              (opperand_of(inst) == opp_str);
        return hit;
    endfunction

    // instructions whose result is the working register
    function automatic logic keeps_working(input logic [7:0] inst);
        logic hit;
        hit = (inst == inst_push) || (inst == inst_call) ||
              (inst == inst_tbm) || (opperand_of(inst) == opp_str);
        return hit;
    endfunction

endpackage
